/* design/img_consts.svh */
// Image preprocessing constants for stream widths, header fields and luma weights
`ifndef IMG_CONSTS_SVH
`define IMG_CONSTS_SVH

// Width of one stream word on the input and output ports
`define IMG_WORD_W 32

// Width of one byte lane and of one color or luma sample
`define IMG_BYTE_W 8

// Number of byte lanes in one stream word
`define IMG_LANES 4

// Width of each header field and of the pixel coordinates
`define IMG_HDR_W 16

// Luma weights in 1/256 units, the three add up to 256
`define IMG_LUMA_R 77
`define IMG_LUMA_G 150
`define IMG_LUMA_B 29
`define IMG_LUMA_SHIFT 8

`endif

/* design/stream_pkg.sv */
// Stream package holding the input word views and the framed word passed to the unpacker
`default_nettype none
`include "img_consts.svh"

package stream_pkg;

    // Image header carried in the first payload word
    // Width sits in the low half and height in the high half
    typedef struct packed {
        logic [`IMG_HDR_W-1:0] height;
        logic [`IMG_HDR_W-1:0] width;
    } img_header_t;

    // One input word, read as a header or as four byte lanes
    // Lane 0 is the least significant byte and is filled first
    typedef union packed {
        img_header_t                               hdr;
        logic [`IMG_LANES-1:0][`IMG_BYTE_W-1:0]    bytes;
    } stream_word_u;

    // Payload word with its strobes and frame position flags
    typedef struct packed {
        stream_word_u          data;
        logic [`IMG_LANES-1:0] strb;
        logic                  first;
        logic                  last;
    } framed_word_t;

endpackage

`default_nettype wire

/* design/pixel_pkg.sv */
// Pixel package holding the decoded RGB pixel and the grayscale sample types
`default_nettype none
`include "img_consts.svh"

package pixel_pkg;

    // Decoded color pixel with its raster position
    // The coordinates match the pixel side of the decoder core
    typedef struct packed {
        logic [`IMG_HDR_W-1:0]  x;
        logic [`IMG_HDR_W-1:0]  y;
        logic [`IMG_BYTE_W-1:0] r;
        logic [`IMG_BYTE_W-1:0] g;
        logic [`IMG_BYTE_W-1:0] b;
    } rgb_pixel_t;

    // Grayscale sample on its way to the word packer
    // The last bit marks the final pixel of the frame and closes the output word
    typedef struct packed {
        logic [`IMG_BYTE_W-1:0] luma;
        logic                   last;
    } gray_pixel_t;

endpackage

`default_nettype wire

/* design/stream_framer.sv */
// Stream framer that counts down the framed byte stream and tags each payload word
`timescale 1ns/10ps
`default_nettype none
`include "img_consts.svh"

module stream_framer (
    input  logic                     clock,
    input  logic                     reset,
    input  stream_pkg::stream_word_u in_data_i,
    input  logic                     in_valid_i,
    output logic                     upstream_stall_o,
    output stream_pkg::framed_word_t word_o,
    output logic                     word_valid_o,
    input  logic                     word_accept_i
);

    // Bytes of the current frame still to arrive, zero means idle
    logic [`IMG_WORD_W-1:0] byte_count;
    // Set between the count load and the header word transfer
    logic                   first_pending;
    logic                   idle;
    logic                   last_word;
    logic                   transfer;
    logic [`IMG_LANES-1:0]  strb;

    assign idle      = (byte_count == '0);
    // Four bytes or fewer left means this word closes the frame
    assign last_word = (byte_count <= `IMG_LANES);
    assign transfer  = word_valid_o && word_accept_i;

    // Strobes follow the remaining count, lanes fill from the LSB
    always_comb begin
        case (byte_count)
            1:       strb = 4'b0001;
            2:       strb = 4'b0011;
            3:       strb = 4'b0111;
            default: strb = 4'b1111;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            byte_count    <= '0;
            first_pending <= 1'b0;
        end else if (idle) begin
            // Any word seen while idle is the byte count of the next frame
            // A zero count simply leaves the framer idle
            if (in_valid_i) begin
                byte_count    <= in_data_i;
                first_pending <= (in_data_i != '0);
            end
        end else if (transfer) begin
            byte_count    <= last_word ? '0 : byte_count - `IMG_LANES;
            first_pending <= 1'b0;
        end
    end

    // The word itself passes straight through to the unpacker
    assign word_o.data  = in_data_i;
    assign word_o.strb  = strb;
    assign word_o.first = first_pending;
    assign word_o.last  = last_word;

    // Nothing is offered downstream while the count is still awaited
    assign word_valid_o = in_valid_i && !idle;

    // The count can always be latched, payload waits for the unpacker
    assign upstream_stall_o = !idle && !word_accept_i;

endmodule

`default_nettype wire

/* design/pixel_unpacker.sv */
// Pixel unpacker that decodes the raw RGB header and serializes payload bytes into pixels
`timescale 1ns/10ps
`default_nettype none
`include "img_consts.svh"

module pixel_unpacker (
    input  logic                     clock,
    input  logic                     reset,
    input  stream_pkg::framed_word_t word_i,
    input  logic                     word_valid_i,
    output logic                     word_accept_o,
    output pixel_pkg::rgb_pixel_t    pix_o,
    output logic                     pix_last_o,
    output logic                     pix_valid_o,
    input  logic                     pix_accept_i
);

    import pixel_pkg::*;

    // Which color byte is expected next
    typedef enum logic [1:0] {
        PH_R,
        PH_G,
        PH_B
    } phase_t;

    logic [`IMG_HDR_W-1:0]         width_q;
    logic [`IMG_HDR_W-1:0]         x_q;
    logic [`IMG_HDR_W-1:0]         y_q;
    logic [$clog2(`IMG_LANES)-1:0] lane_q;
    phase_t                        phase_q;
    logic [`IMG_BYTE_W-1:0]        r_q;
    logic [`IMG_BYTE_W-1:0]        g_q;
    logic [`IMG_BYTE_W-1:0]        cur_byte;
    logic [`IMG_LANES-1:0]         strb_rest;
    logic                          last_lane;
    logic                          hold;
    logic                          take_hdr;
    logic                          take_byte;
    rgb_pixel_t                    pix_q;
    logic                          pix_last_q;
    logic                          pix_valid_q;

    // Byte under the lane pointer, read through the byte view of the word
    assign cur_byte  = word_i.data.bytes[lane_q];

    // Strobes are contiguous from the LSB, so the current lane is the last
    // one of the word when the next strobe bit is clear or there is no next lane
    assign strb_rest = word_i.strb >> (lane_q + 1);
    assign last_lane = !strb_rest[0];

    // A full pixel register that is not being taken pauses the byte walk
    assign hold      = pix_valid_q && !pix_accept_i;
    assign take_hdr  = word_valid_i && word_i.first;
    assign take_byte = word_valid_i && !word_i.first && !hold;

    // The header goes in one cycle, a payload word when its last byte is taken
    assign word_accept_o = take_hdr || (take_byte && last_lane);

    always_ff @(posedge clock) begin
        if (reset) begin
            width_q     <= '0;
            x_q         <= '0;
            y_q         <= '0;
            lane_q      <= '0;
            phase_q     <= PH_R;
            pix_valid_q <= 1'b0;
        end else begin
            if (pix_valid_q && pix_accept_i) begin
                pix_valid_q <= 1'b0;
            end
            if (take_hdr) begin
                // Header view gives the line width for the coordinate wrap
                width_q <= word_i.data.hdr.width;
                x_q     <= '0;
                y_q     <= '0;
                lane_q  <= '0;
                phase_q <= PH_R;
            end else if (take_byte) begin
                lane_q <= last_lane ? '0 : lane_q + 1'b1;
                case (phase_q)
                    PH_R: begin
                        phase_q <= PH_G;
                    end
                    PH_G: begin
                        phase_q <= PH_B;
                    end
                    default: begin
                        // Blue completes the pixel, which is registered here
                        phase_q     <= PH_R;
                        pix_valid_q <= 1'b1;
                        if (x_q == width_q - 1'b1) begin
                            x_q <= '0;
                            y_q <= y_q + 1'b1;
                        end else begin
                            x_q <= x_q + 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    // Color bytes and the finished pixel carry no reset
    always_ff @(posedge clock) begin
        if (take_byte) begin
            if (phase_q == PH_R) begin
                r_q <= cur_byte;
            end
            if (phase_q == PH_G) begin
                g_q <= cur_byte;
            end
            if (phase_q == PH_B) begin
                pix_q      <= '{x: x_q, y: y_q, r: r_q, g: g_q, b: cur_byte};
                // Only the final byte of the closing word ends the frame
                pix_last_q <= word_i.last && last_lane;
            end
        end
    end

    assign pix_o       = pix_q;
    assign pix_last_o  = pix_last_q;
    assign pix_valid_o = pix_valid_q;

endmodule

`default_nettype wire

/* design/gray_converter.sv */
// Grayscale converter that registers the weighted luma of each RGB pixel
`timescale 1ns/10ps
`default_nettype none
`include "img_consts.svh"

module gray_converter (
    input  logic                   clock,
    input  logic                   reset,
    input  pixel_pkg::rgb_pixel_t  pix_i,
    input  logic                   pix_last_i,
    input  logic                   pix_valid_i,
    output logic                   pix_accept_o,
    output pixel_pkg::gray_pixel_t gray_o,
    output logic                   gray_valid_o,
    input  logic                   gray_accept_i
);

    import pixel_pkg::*;

    // The weights add up to 256, so the full sum fits in 16 bits
    logic [15:0]  luma_sum;
    gray_pixel_t  gray_q;
    logic         gray_valid_q;

    assign luma_sum = 16'(`IMG_LUMA_R * pix_i.r + `IMG_LUMA_G * pix_i.g + `IMG_LUMA_B * pix_i.b);

    // Room exists when the register is empty or its item leaves this cycle
    assign pix_accept_o = !gray_valid_q || gray_accept_i;

    always_ff @(posedge clock) begin
        if (reset) begin
            gray_valid_q <= 1'b0;
        end else if (pix_accept_o) begin
            gray_valid_q <= pix_valid_i;
        end
    end

    // The sample itself is loaded without reset
    always_ff @(posedge clock) begin
        if (pix_valid_i && pix_accept_o) begin
            gray_q <= '{luma: luma_sum[`IMG_LUMA_SHIFT +: `IMG_BYTE_W], last: pix_last_i};
        end
    end

    assign gray_o       = gray_q;
    assign gray_valid_o = gray_valid_q;

endmodule

`default_nettype wire

/* design/word_packer.sv */
// Word packer that gathers four gray bytes per output word and holds it under stall
`timescale 1ns/10ps
`default_nettype none
`include "img_consts.svh"

module word_packer (
    input  logic                   clock,
    input  logic                   reset,
    input  pixel_pkg::gray_pixel_t gray_i,
    input  logic                   gray_valid_i,
    output logic                   gray_accept_o,
    output logic [`IMG_WORD_W-1:0] out_data_o,
    output logic                   out_valid_o,
    input  logic                   downstream_stall_i
);

    // Bytes gathered so far for the word under construction
    logic [`IMG_LANES-1:0][`IMG_BYTE_W-1:0] buf_q;
    logic [`IMG_LANES-1:0][`IMG_BYTE_W-1:0] word_next;
    // Number of lanes already filled, also the lane for the next byte
    logic [$clog2(`IMG_LANES)-1:0]          fill_q;
    logic [`IMG_WORD_W-1:0]                 out_data_q;
    logic                                   out_valid_q;
    logic                                   take;
    logic                                   emit;

    // A word waiting under stall blocks every new sample
    assign gray_accept_o = !(out_valid_q && downstream_stall_i);
    assign take          = gray_valid_i && gray_accept_o;
    // The fourth byte or a frame end closes the word
    assign emit          = take && ((fill_q == `IMG_LANES - 1) || gray_i.last);

    // Filled lanes, the incoming byte in the next lane, zeros above it
    always_comb begin
        word_next = '0;
        for (int i = 0; i < `IMG_LANES; i++) begin
            if (i < fill_q) begin
                word_next[i] = buf_q[i];
            end
        end
        word_next[fill_q] = gray_i.luma;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            fill_q      <= '0;
            out_valid_q <= 1'b0;
        end else begin
            if (out_valid_q && !downstream_stall_i) begin
                out_valid_q <= 1'b0;
            end
            if (emit) begin
                fill_q      <= '0;
                out_valid_q <= 1'b1;
            end else if (take) begin
                fill_q <= fill_q + 1'b1;
            end
        end
    end

    // Payload registers load on a transfer only and carry no reset
    always_ff @(posedge clock) begin
        if (take) begin
            buf_q[fill_q] <= gray_i.luma;
        end
        if (emit) begin
            out_data_q <= word_next;
        end
    end

    assign out_data_o  = out_data_q;
    assign out_valid_o = out_valid_q;

endmodule

`default_nettype wire

/* design/img_preproc_top.sv */
// Image preprocessing top that turns a framed raw RGB stream into packed grayscale words
`timescale 1ns/10ps
`default_nettype none
`include "img_consts.svh"

module img_preproc_top (
    input  logic                     clock,
    input  logic                     reset,
    input  stream_pkg::stream_word_u in_data_i,
    input  logic                     in_valid_i,
    output logic                     upstream_stall_o,
    output logic [`IMG_WORD_W-1:0]   out_data_o,
    output logic                     out_valid_o,
    input  logic                     downstream_stall_i
);

    import stream_pkg::*;
    import pixel_pkg::*;

    // Framer to unpacker
    framed_word_t word;
    logic         word_valid;
    logic         word_accept;

    // Unpacker to converter
    rgb_pixel_t   pix;
    logic         pix_last;
    logic         pix_valid;
    logic         pix_accept;

    // Converter to packer
    gray_pixel_t  gray;
    logic         gray_valid;
    logic         gray_accept;

    // Byte count tracking, strobes and the upstream stall
    stream_framer u_framer (
        .clock            (clock),
        .reset            (reset),
        .in_data_i        (in_data_i),
        .in_valid_i       (in_valid_i),
        .upstream_stall_o (upstream_stall_o),
        .word_o           (word),
        .word_valid_o     (word_valid),
        .word_accept_i    (word_accept)
    );

    // Raw RGB decoder in the slot of the original image decoder core
    pixel_unpacker u_unpacker (
        .clock         (clock),
        .reset         (reset),
        .word_i        (word),
        .word_valid_i  (word_valid),
        .word_accept_o (word_accept),
        .pix_o         (pix),
        .pix_last_o    (pix_last),
        .pix_valid_o   (pix_valid),
        .pix_accept_i  (pix_accept)
    );

    gray_converter u_gray (
        .clock         (clock),
        .reset         (reset),
        .pix_i         (pix),
        .pix_last_i    (pix_last),
        .pix_valid_i   (pix_valid),
        .pix_accept_o  (pix_accept),
        .gray_o        (gray),
        .gray_valid_o  (gray_valid),
        .gray_accept_i (gray_accept)
    );

    // Output words hold while the downstream side stalls
    word_packer u_packer (
        .clock              (clock),
        .reset              (reset),
        .gray_i             (gray),
        .gray_valid_i       (gray_valid),
        .gray_accept_o      (gray_accept),
        .out_data_o         (out_data_o),
        .out_valid_o        (out_valid_o),
        .downstream_stall_i (downstream_stall_i)
    );

endmodule

`default_nettype wire

/* bench/img_preproc_sva.sv */
// Protocol checker for the image preprocessing top covering reset, stall and handshakes
`timescale 1ns/10ps
`default_nettype none

module img_preproc_sva (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     upstream_stall_o,
    input  logic [31:0]              out_data_o,
    input  logic                     out_valid_o,
    input  logic                     downstream_stall_i,
    input  stream_pkg::framed_word_t word,
    input  logic                     word_valid,
    input  logic                     word_accept,
    input  pixel_pkg::rgb_pixel_t    pix,
    input  logic                     pix_last,
    input  logic                     pix_valid,
    input  logic                     pix_accept,
    input  pixel_pkg::gray_pixel_t   gray,
    input  logic                     gray_valid,
    input  logic                     gray_accept
);

    // Number of assertion failures seen so far
    int fail_count = 0;

    // Every valid and the upstream stall come out of reset low
    a_reset_quiet: assert property (@(posedge clock)
        reset |=> !out_valid_o && !upstream_stall_o && !pix_valid && !gray_valid)
        else begin
            $error("outputs or internal valids were not low after reset");
            fail_count++;
        end

    // An output word under stall stays put until it is taken
    a_out_hold: assert property (@(posedge clock) disable iff (reset)
        out_valid_o && downstream_stall_i |=> out_valid_o && $stable(out_data_o))
        else begin
            $error("output word changed or dropped under downstream stall");
            fail_count++;
        end

    // Internal links keep valid and data steady until the transfer
    a_word_hold: assert property (@(posedge clock) disable iff (reset)
        word_valid && !word_accept |=> word_valid && $stable(word))
        else begin
            $error("framed word changed before the unpacker took it");
            fail_count++;
        end

    a_pix_hold: assert property (@(posedge clock) disable iff (reset)
        pix_valid && !pix_accept |=> pix_valid && $stable(pix) && $stable(pix_last))
        else begin
            $error("RGB pixel changed before the converter took it");
            fail_count++;
        end

    a_gray_hold: assert property (@(posedge clock) disable iff (reset)
        gray_valid && !gray_accept |=> gray_valid && $stable(gray))
        else begin
            $error("gray sample changed before the packer took it");
            fail_count++;
        end

endmodule

// The checker sees the top ports and the links between the four stages
bind img_preproc_top img_preproc_sva u_sva (
    .clock              (clock),
    .reset              (reset),
    .upstream_stall_o   (upstream_stall_o),
    .out_data_o         (out_data_o),
    .out_valid_o        (out_valid_o),
    .downstream_stall_i (downstream_stall_i),
    .word               (word),
    .word_valid         (word_valid),
    .word_accept        (word_accept),
    .pix                (pix),
    .pix_last           (pix_last),
    .pix_valid          (pix_valid),
    .pix_accept         (pix_accept),
    .gray               (gray),
    .gray_valid         (gray_valid),
    .gray_accept        (gray_accept)
);

`default_nettype wire

/* bench/img_preproc_tb.sv */
// Testbench for the image preprocessing top with random raw RGB frames and a luma model
`timescale 1ns/10ps
`default_nettype none
`include "img_consts.svh"

module img_preproc_tb;

    import stream_pkg::*;

    localparam int NUM_FRAMES = 8;

    logic                   clock;
    logic                   reset;
    stream_word_u           in_data_i;
    logic                   in_valid_i;
    logic                   upstream_stall_o;
    logic [`IMG_WORD_W-1:0] out_data_o;
    logic                   out_valid_o;
    logic                   downstream_stall_i;

    integer      seed;
    int          frame_w [NUM_FRAMES];
    int          frame_h [NUM_FRAMES];
    int          frame_base [NUM_FRAMES];
    int          fixed_w [4] = '{3, 5, 4, 1};
    int          fixed_h [4] = '{2, 1, 4, 1};
    logic [7:0]  pix_bytes [$];
    // Expected output words in order, each with the frame it belongs to
    logic [31:0] exp_q [$];
    string       exp_name [$];
    logic [31:0] exp_head;
    string       head_name;
    logic        exp_avail;
    logic        accept_q;
    int          cycle_limit;
    logic        limit_ready;

    img_preproc_top dut (
        .clock              (clock),
        .reset              (reset),
        .in_data_i          (in_data_i),
        .in_valid_i         (in_valid_i),
        .upstream_stall_o   (upstream_stall_o),
        .out_data_o         (out_data_o),
        .out_valid_o        (out_valid_o),
        .downstream_stall_i (downstream_stall_i)
    );

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic refresh_head();
        exp_avail = (exp_q.size() != 0);
        exp_head  = exp_avail ? exp_q[0] : '0;
        head_name = exp_avail ? exp_name[0] : "none";
    endtask

    // Holds the word on the bus until a cycle ends with the stall low
    task automatic send_word(input logic [31:0] data);
        logic taken;
        in_data_i  = data;
        in_valid_i = 1'b1;
        taken      = 1'b0;
        while (!taken) begin
            @(negedge clock);
            taken = !upstream_stall_o;
            @(posedge clock);
            #5;
        end
        in_valid_i = 1'b0;
    endtask

    // Sometimes leaves in_valid_i low for a few cycles
    task automatic random_pause();
        int gap;
        gap = $unsigned($random(seed)) % 8;
        if (gap > 3) begin
            gap = 0;
        end
        repeat (gap) begin
            @(posedge clock);
            #5;
        end
    endtask

    // Luma of each pixel, four per word from the LSB, zeros above the last one
    task automatic push_expected(input int idx);
        logic [31:0] acc;
        int          lane;
        int          npix;
        int          sum;
        int          b;
        acc  = '0;
        lane = 0;
        npix = frame_w[idx] * frame_h[idx];
        for (int p = 0; p < npix; p++) begin
            b   = frame_base[idx] + 3 * p;
            sum = `IMG_LUMA_R * pix_bytes[b] + `IMG_LUMA_G * pix_bytes[b + 1]
                + `IMG_LUMA_B * pix_bytes[b + 2];
            acc[lane * 8 +: 8] = 8'(sum >> `IMG_LUMA_SHIFT);
            lane++;
            if (lane == `IMG_LANES || p == npix - 1) begin
                exp_q.push_back(acc);
                exp_name.push_back($sformatf("frame_%0d_%0dx%0d", idx, frame_w[idx], frame_h[idx]));
                acc  = '0;
                lane = 0;
            end
        end
        refresh_head();
    endtask

    // Byte count, header, then payload words with junk in the unstrobed lanes
    task automatic send_frame(input int idx);
        int          nbytes;
        logic [31:0] w;
        nbytes = 3 * frame_w[idx] * frame_h[idx];
        send_word(32'(nbytes + `IMG_LANES));
        send_word({16'(frame_h[idx]), 16'(frame_w[idx])});
        for (int i = 0; i < nbytes; i += 4) begin
            w = 32'($random(seed));
            for (int l = 0; l < 4; l++) begin
                if (i + l < nbytes) begin
                    w[l * 8 +: 8] = pix_bytes[frame_base[idx] + i + l];
                end
            end
            random_pause();
            send_word(w);
        end
    endtask

    initial begin : clock_gen
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

    initial begin : stall_gen
        forever begin
            @(posedge clock);
            #5;
            downstream_stall_i = reset ? 1'b0 : 1'($random(seed) & 1);
        end
    end

    // An accepted word is noted at the edge and retired at the next falling edge
    always @(posedge clock) begin
        accept_q <= !reset && out_valid_o && !downstream_stall_i;
    end

    always @(negedge clock) begin
        if (accept_q && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
            void'(exp_name.pop_front());
            refresh_head();
        end
    end

    check_data: assert property (@(posedge clock) disable iff (reset)
        (out_valid_o && !downstream_stall_i && exp_avail) |-> (out_data_o == exp_head))
        else fail_run($sformatf("MISMATCH test=%s expected=%08h actual=%08h",
                                head_name, $sampled(exp_head), $sampled(out_data_o)));

    check_extra: assert property (@(posedge clock) disable iff (reset)
        (out_valid_o && !downstream_stall_i) |-> exp_avail)
        else fail_run("an output word arrived when no word was expected");

    // Failed protocol assertions of the bound checker
    always @(negedge clock) begin
        if (dut.u_sva.fail_count != 0) begin
            fail_run("a protocol assertion failed in the bound checker");
        end
    end

    // Run length scales with the bytes sent, four cycles per byte leaves room for stalls
    initial begin : watchdog
        wait (limit_ready);
        repeat (cycle_limit) @(posedge clock);
        fail_run("watchdog timeout, the output words did not all arrive in time");
    end

    initial begin : stimulus
        int total_bytes;
        int npix;
        seed               = 32'haad699d2;
        reset              = 1'b1;
        in_data_i          = '0;
        in_valid_i         = 1'b0;
        downstream_stall_i = 1'b0;
        accept_q           = 1'b0;
        limit_ready        = 1'b0;
        total_bytes        = 0;
        refresh_head();
        // The first frames give partial last words and a zero filled last output word
        for (int f = 0; f < NUM_FRAMES; f++) begin
            if (f < 4) begin
                frame_w[f] = fixed_w[f];
                frame_h[f] = fixed_h[f];
            end else begin
                frame_w[f] = 1 + $unsigned($random(seed)) % 7;
                frame_h[f] = 1 + $unsigned($random(seed)) % 4;
            end
            frame_base[f] = pix_bytes.size();
            npix          = frame_w[f] * frame_h[f];
            for (int i = 0; i < 3 * npix; i++) begin
                pix_bytes.push_back(8'($random(seed)));
            end
            total_bytes += 3 * npix + 8;
        end
        cycle_limit = total_bytes * 4 + 500;
        limit_ready = 1'b1;
        repeat (2) @(posedge clock);
        #5;
        reset = 1'b0;
        // A zero count while idle must leave the pipeline quiet
        send_word('0);
        repeat (4) begin
            @(posedge clock);
            #5;
        end
        for (int f = 0; f < NUM_FRAMES; f++) begin
            push_expected(f);
            send_frame(f);
            if (f == 2) begin
                send_word('0);
            end
        end
        while (exp_q.size() != 0) begin
            @(posedge clock);
        end
        repeat (20) @(posedge clock);
        @(negedge clock);
        if (dut.u_sva.fail_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            fail_run("a protocol assertion failed in the bound checker");
        end
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+design
design/stream_pkg.sv
design/pixel_pkg.sv
design/stream_framer.sv
design/pixel_unpacker.sv
design/gray_converter.sv
design/word_packer.sv
design/img_preproc_top.sv
bench/img_preproc_sva.sv
bench/img_preproc_tb.sv
